// File: pixelUtil.svh
// ================================================
// Pixel utility macros
// Function generators for channel saturation
// ================================================
`ifndef PIXEL_UTIL_SVH
`define PIXEL_UTIL_SVH

// Generates funcName, which clamps a signed inWidth value to the signed
// outWidth range, for example -256 to 255 for nine bits
`define ReduceAndSaturateSigned(funcName, inWidth, outWidth) \
    function automatic logic [(outWidth) - 1 : 0] funcName( \
        input logic signed [(inWidth) - 1 : 0] value \
    ); \
        logic signed [(inWidth) - 1 : 0] upper; \
        logic signed [(inWidth) - 1 : 0] lower; \
        upper = '0; \
        upper[(outWidth) - 2 : 0] = '1; \
        lower = ~upper; \
        if (value > upper) \
            return upper[(outWidth) - 1 : 0]; \
        else if (value < lower) \
            return lower[(outWidth) - 1 : 0]; \
        else \
            return value[(outWidth) - 1 : 0]; \
    endfunction

// Generates funcName, which turns a signed value into an unsigned channel
// Negative gives zero, otherwise the low bits are kept
`define ClampToUnsignedChannel(funcName, inWidth, outWidth) \
    function automatic logic [(outWidth) - 1 : 0] funcName( \
        input logic signed [(inWidth) - 1 : 0] value \
    ); \
        if (value[(inWidth) - 1]) \
            return '0; \
        else \
            return value[(outWidth) - 1 : 0]; \
    endfunction

`endif

// File: combinerPkg.sv
// ================================================
// Texture combiner package
// Widths, combine mode codes and stage latencies
// ================================================
package combinerPkg;

    // Unsigned RGBA color, red in the low byte
    localparam int CHANNEL_WIDTH = 8;
    localparam int CHANNEL_COUNT = 4;
    localparam int COLOR_WIDTH = CHANNEL_WIDTH * CHANNEL_COUNT;

    // Signed operand channel, one extra bit for the sign
    localparam int SUB_PIXEL_WIDTH = CHANNEL_WIDTH + 1;
    localparam int SIGNED_COLOR_WIDTH = SUB_PIXEL_WIDTH * CHANNEL_COUNT;

    // Combine mode codes, 5 to 7 act as replace
    localparam int MODE_WIDTH = 3;
    localparam logic [MODE_WIDTH - 1 : 0] MODE_REPLACE = 3'd0;
    localparam logic [MODE_WIDTH - 1 : 0] MODE_MODULATE = 3'd1;
    localparam logic [MODE_WIDTH - 1 : 0] MODE_ADD = 3'd2;
    localparam logic [MODE_WIDTH - 1 : 0] MODE_SUBTRACT = 3'd3;
    localparam logic [MODE_WIDTH - 1 : 0] MODE_INTERPOLATE = 3'd4;

    // 255 stands for 1.0
    localparam logic signed [SUB_PIXEL_WIDTH - 1 : 0] CHANNEL_ONE = 9'sd255;
    localparam logic signed [SUB_PIXEL_WIDTH - 1 : 0] CHANNEL_MINUS_ONE = -9'sd255;

    // Stage latencies in cycles
    localparam int SELECT_DEPTH = 1;
    localparam int MIXER_DEPTH = 2;
    localparam int OUTPUT_DEPTH = 1;
    localparam int COMBINER_LATENCY = SELECT_DEPTH + MIXER_DEPTH + OUTPUT_DEPTH;

endpackage

// File: mixerOperandIf.sv
// ================================================
// Mixer operand bus
// Valid strobe and four signed operand colors
// ================================================
`timescale 1ns/100ps

interface mixerOperandIf;
    import combinerPkg::*;

    logic                              valid;
    logic [SIGNED_COLOR_WIDTH - 1 : 0] colorA;
    logic [SIGNED_COLOR_WIDTH - 1 : 0] colorB;
    logic [SIGNED_COLOR_WIDTH - 1 : 0] colorC;
    logic [SIGNED_COLOR_WIDTH - 1 : 0] colorD;

    modport source (
        output valid,
        output colorA,
        output colorB,
        output colorC,
        output colorD
    );

    // Mixer side only needs the operand colors
    modport sink (
        input colorA,
        input colorB,
        input colorC,
        input colorD
    );

    modport validSink (
        input valid
    );

endinterface

// File: combinerOperandSelect.sv
// ================================================
// Combiner operand select
// Decodes the combine mode, registers A, B, C, D
// ================================================
`timescale 1ns/100ps

module combinerOperandSelect (
    input  logic                                  aclk,
    input  logic                                  arstN,
    input  logic                                  inValid,
    input  logic [combinerPkg::MODE_WIDTH - 1 : 0]  combineMode,
    input  logic [combinerPkg::COLOR_WIDTH - 1 : 0] primaryColor,
    input  logic [combinerPkg::COLOR_WIDTH - 1 : 0] textureColor,
    input  logic [combinerPkg::COLOR_WIDTH - 1 : 0] constantColor,
    mixerOperandIf.source                         operands
);
    import combinerPkg::*;

    // Zero extended input channels
    logic signed [SUB_PIXEL_WIDTH - 1 : 0] primary [CHANNEL_COUNT];
    logic signed [SUB_PIXEL_WIDTH - 1 : 0] texel [CHANNEL_COUNT];
    logic signed [SUB_PIXEL_WIDTH - 1 : 0] constant [CHANNEL_COUNT];
    logic signed [SUB_PIXEL_WIDTH - 1 : 0] inverseConstant [CHANNEL_COUNT];

    // Selected operands before the register
    logic signed [SUB_PIXEL_WIDTH - 1 : 0] opA [CHANNEL_COUNT];
    logic signed [SUB_PIXEL_WIDTH - 1 : 0] opB [CHANNEL_COUNT];
    logic signed [SUB_PIXEL_WIDTH - 1 : 0] opC [CHANNEL_COUNT];
    logic signed [SUB_PIXEL_WIDTH - 1 : 0] opD [CHANNEL_COUNT];

    always_comb
    begin
        for (int i = 0; i < CHANNEL_COUNT; i++)
        begin
            primary[i] = {1'b0, primaryColor[i * CHANNEL_WIDTH +: CHANNEL_WIDTH]};
            texel[i] = {1'b0, textureColor[i * CHANNEL_WIDTH +: CHANNEL_WIDTH]};
            constant[i] = {1'b0, constantColor[i * CHANNEL_WIDTH +: CHANNEL_WIDTH]};
            // 1.0 - constant, stays within 0 to 255
            inverseConstant[i] = CHANNEL_ONE - constant[i];

            // Replace operands, texture times one
            opA[i] = texel[i];
            opB[i] = CHANNEL_ONE;
            opC[i] = '0;
            opD[i] = '0;

            case (combineMode)
                MODE_MODULATE:
                begin
                    opB[i] = primary[i];
                end
                MODE_ADD:
                begin
                    opC[i] = primary[i];
                    opD[i] = CHANNEL_ONE;
                end
                MODE_SUBTRACT:
                begin
                    // Texture minus primary
                    opC[i] = primary[i];
                    opD[i] = CHANNEL_MINUS_ONE;
                end
                MODE_INTERPOLATE:
                begin
                    opB[i] = constant[i];
                    opC[i] = primary[i];
                    opD[i] = inverseConstant[i];
                end
                default:
                begin
                    // MODE_REPLACE and codes 5 to 7 keep the replace operands
                end
            endcase
        end
    end

    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            operands.valid <= 1'b0;
        end
        else
        begin
            operands.valid <= inValid;
        end
    end

    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < CHANNEL_COUNT; i++)
        begin
            operands.colorA[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH] <= opA[i];
            operands.colorB[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH] <= opB[i];
            operands.colorC[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH] <= opC[i];
            operands.colorD[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH] <= opD[i];
        end
    end

endmodule

// File: colorMixerSigned.sv
// ================================================
// Signed color mixer
// (A * B) + (C * D), rounded and saturated, 2 cycles
// ================================================
`timescale 1ns/100ps

`include "pixelUtil.svh"

module colorMixerSigned #(
    parameter int SUB_PIXEL_WIDTH = combinerPkg::SUB_PIXEL_WIDTH
) (
    input  logic                                                    aclk,
    input  logic                                                    arstN,
    mixerOperandIf.sink                                             operands,
    output logic [SUB_PIXEL_WIDTH * combinerPkg::CHANNEL_COUNT - 1 : 0] mixedColor
);
    import combinerPkg::*;

    localparam int FRACTION_WIDTH = SUB_PIXEL_WIDTH - 1;
    localparam int PRODUCT_WIDTH = 2 * SUB_PIXEL_WIDTH;
    // One carry bit for the sum of two products and the rounding term
    localparam int SUM_WIDTH = PRODUCT_WIDTH + 1;

    // 1.0 in the channel scale, also used as rounding offset
    localparam logic signed [SUM_WIDTH - 1 : 0] ONE_DOT_ZERO = (1 << FRACTION_WIDTH) - 1;

    `ReduceAndSaturateSigned(saturateChannel, SUM_WIDTH, SUB_PIXEL_WIDTH)

    logic signed [PRODUCT_WIDTH - 1 : 0] productAb [CHANNEL_COUNT];
    logic signed [PRODUCT_WIDTH - 1 : 0] productCd [CHANNEL_COUNT];
    logic signed [SUM_WIDTH - 1 : 0] roundedSum [CHANNEL_COUNT];
    logic [SUB_PIXEL_WIDTH * CHANNEL_COUNT - 1 : 0] saturatedColor;

    // First cycle, products per channel
    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < CHANNEL_COUNT; i++)
        begin
            productAb[i] <=
                $signed(operands.colorA[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH]) *
                $signed(operands.colorB[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH]);
            productCd[i] <=
                $signed(operands.colorC[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH]) *
                $signed(operands.colorD[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH]);
        end
    end

    // Back to channel scale, divides by 256 after adding 255
    always_comb
    begin
        for (int i = 0; i < CHANNEL_COUNT; i++)
        begin
            roundedSum[i] = (productAb[i] + productCd[i] + ONE_DOT_ZERO) >>> FRACTION_WIDTH;
            saturatedColor[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH] =
                saturateChannel(roundedSum[i]);
        end
    end

    // Second cycle
    always_ff @(posedge aclk)
    begin
        mixedColor <= saturatedColor;
    end

endmodule

// File: combinerOutputStage.sv
// ================================================
// Combiner output stage
// Aligns valid with the mixer, clamps to bytes
// ================================================
`timescale 1ns/100ps

`include "pixelUtil.svh"

module combinerOutputStage (
    input  logic                                         aclk,
    input  logic                                         arstN,
    mixerOperandIf.validSink                             operands,
    input  logic [combinerPkg::SIGNED_COLOR_WIDTH - 1 : 0] mixedColor,
    output logic                                         outValid,
    output logic [combinerPkg::COLOR_WIDTH - 1 : 0]        outColor
);
    import combinerPkg::*;

    // Mixer depth plus this stage
    localparam int VALID_DELAY = COMBINER_LATENCY - SELECT_DEPTH;

    `ClampToUnsignedChannel(clampChannel, SUB_PIXEL_WIDTH, CHANNEL_WIDTH)

    logic [VALID_DELAY - 1 : 0] validLine;

    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            validLine <= '0;
        end
        else
        begin
            // Oldest entry falls off the top
            validLine <= VALID_DELAY'({validLine, operands.valid});
        end
    end

    assign outValid = validLine[VALID_DELAY - 1];

    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < CHANNEL_COUNT; i++)
        begin
            outColor[i * CHANNEL_WIDTH +: CHANNEL_WIDTH] <=
                clampChannel(mixedColor[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH]);
        end
    end

endmodule

// File: texEnvCombiner.sv
// ================================================
// Texture environment combiner top level
// Operand select, signed mixer and output clamp
// ================================================
`timescale 1ns/100ps

module texEnvCombiner (
    input  logic                                  aclk,
    input  logic                                  arstN,

    // Fragment in, one per cycle at most
    input  logic                                  inValid,
    input  logic [combinerPkg::MODE_WIDTH - 1 : 0]  combineMode,
    input  logic [combinerPkg::COLOR_WIDTH - 1 : 0] primaryColor,
    input  logic [combinerPkg::COLOR_WIDTH - 1 : 0] textureColor,
    input  logic [combinerPkg::COLOR_WIDTH - 1 : 0] constantColor,

    // Combined color, four cycles later
    output logic                                  outValid,
    output logic [combinerPkg::COLOR_WIDTH - 1 : 0] outColor
);
    import combinerPkg::*;

    logic [SIGNED_COLOR_WIDTH - 1 : 0] mixedColor;

    mixerOperandIf operandBus0 ();

    combinerOperandSelect operandSelect0 (
        .aclk          (aclk),
        .arstN         (arstN),
        .inValid       (inValid),
        .combineMode   (combineMode),
        .primaryColor  (primaryColor),
        .textureColor  (textureColor),
        .constantColor (constantColor),
        .operands      (operandBus0.source)
    );

    colorMixerSigned #(
        .SUB_PIXEL_WIDTH (SUB_PIXEL_WIDTH)
    ) mixer0 (
        .aclk       (aclk),
        .arstN      (arstN),
        .operands   (operandBus0.sink),
        .mixedColor (mixedColor)
    );

    // Valid skips the mixer and is delayed here instead
    combinerOutputStage outputStage0 (
        .aclk       (aclk),
        .arstN      (arstN),
        .operands   (operandBus0.validSink),
        .mixedColor (mixedColor),
        .outValid   (outValid),
        .outColor   (outColor)
    );

endmodule

// File: texEnvCombiner_sva.sv
// ================================================
// Texture combiner assertions
// Reset, valid latency and known output color
// ================================================
`timescale 1ns/100ps

module texEnvCombinerSva (
    input  logic                                  aclk,
    input  logic                                  arstN,
    input  logic                                  inValid,
    input  logic                                  outValid,
    input  logic [combinerPkg::COLOR_WIDTH - 1 : 0] outColor
);
    import combinerPkg::*;

    // Pipeline is empty while held in reset
    resetQuiet: assert property (
        @(posedge aclk) !arstN |-> !outValid
    ) else $error("outValid is high while arstN is low");

    // Every fragment comes out a fixed number of cycles later
    latencyMatch: assert property (
        @(posedge aclk) disable iff (!arstN)
        outValid == $past(inValid, COMBINER_LATENCY)
    ) else $error("outValid does not follow inValid by the combiner latency");

    knownColor: assert property (
        @(posedge aclk) disable iff (!arstN)
        outValid |-> !$isunknown(outColor)
    ) else $error("outColor has unknown bits while outValid is high");

endmodule

bind texEnvCombiner texEnvCombinerSva sva0 (
    .aclk     (aclk),
    .arstN    (arstN),
    .inValid  (inValid),
    .outValid (outValid),
    .outColor (outColor)
);

// File: tbTexEnvCombiner.sv
// ================================================
// Texture environment combiner testbench
// Random and directed fragments against a model
// ================================================
`timescale 1ns/100ps

module tbTexEnvCombiner;
    import combinerPkg::*;

    localparam int CLOCK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_CYCLES = 3000;
    localparam int EXTREME_CYCLES = 500;
    localparam int DIRECTED_CYCLES = 16;
    localparam int DRAIN_LIMIT = 10;
    localparam int TOTAL_CYCLES = RANDOM_CYCLES + EXTREME_CYCLES + DIRECTED_CYCLES;
    localparam logic [31 : 0] SEED = 32'h3f3d_4a01;

    logic                         aclk;
    logic                         arstN;
    logic                         inValid;
    logic [MODE_WIDTH - 1 : 0]    combineMode;
    logic [COLOR_WIDTH - 1 : 0]   primaryColor;
    logic [COLOR_WIDTH - 1 : 0]   textureColor;
    logic [COLOR_WIDTH - 1 : 0]   constantColor;
    logic                         outValid;
    logic [COLOR_WIDTH - 1 : 0]   outColor;

    // Fragments in flight, oldest first
    logic [COLOR_WIDTH - 1 : 0]   expectedColors [$];
    string                        expectedTests [$];
    logic [COLOR_WIDTH - 1 : 0]   checkExpected;
    string                        checkTest;

    int mismatchCount;
    int unexpectedCount;
    int missingCount;
    int checkedCount;
    int drainCycles;

    texEnvCombiner dut0 (
        .aclk          (aclk),
        .arstN         (arstN),
        .inValid       (inValid),
        .combineMode   (combineMode),
        .primaryColor  (primaryColor),
        .textureColor  (textureColor),
        .constantColor (constantColor),
        .outValid      (outValid),
        .outColor      (outColor)
    );

    always #(CLOCK_PERIOD / 2) aclk = ~aclk;

    // Per channel: pick A, B, C, D, round, saturate, clamp
    function automatic logic [COLOR_WIDTH - 1 : 0] modelColor(
        input logic [MODE_WIDTH - 1 : 0]  mode,
        input logic [COLOR_WIDTH - 1 : 0] primary,
        input logic [COLOR_WIDTH - 1 : 0] texture,
        input logic [COLOR_WIDTH - 1 : 0] constColor
    );
        logic [COLOR_WIDTH - 1 : 0] result;
        int p;
        int t;
        int k;
        int a;
        int b;
        int c;
        int d;
        int sum;
        result = '0;
        for (int i = 0; i < CHANNEL_COUNT; i++)
        begin
            p = int'(primary[i * CHANNEL_WIDTH +: CHANNEL_WIDTH]);
            t = int'(texture[i * CHANNEL_WIDTH +: CHANNEL_WIDTH]);
            k = int'(constColor[i * CHANNEL_WIDTH +: CHANNEL_WIDTH]);
            a = t;
            b = 255;
            c = 0;
            d = 0;
            case (mode)
                MODE_MODULATE:    b = p;
                MODE_ADD:
                begin
                    c = p;
                    d = 255;
                end
                MODE_SUBTRACT:
                begin
                    c = p;
                    d = -255;
                end
                MODE_INTERPOLATE:
                begin
                    b = k;
                    c = p;
                    d = 255 - k;
                end
                default:          b = 255;
            endcase
            sum = (a * b + c * d + 255) >>> 8;
            if (sum > 255)
                sum = 255;
            else if (sum < -256)
                sum = -256;
            if (sum < 0)
                sum = 0;
            result[i * CHANNEL_WIDTH +: CHANNEL_WIDTH] = 8'(sum);
        end
        return result;
    endfunction

    function automatic string modeName(input logic [MODE_WIDTH - 1 : 0] mode);
        case (mode)
            MODE_MODULATE:    return "modulate";
            MODE_ADD:         return "add";
            MODE_SUBTRACT:    return "subtract";
            MODE_INTERPOLATE: return "interpolate";
            default:          return "replace";
        endcase
    endfunction

    // Each channel is 0, 255 or a random byte
    function automatic logic [COLOR_WIDTH - 1 : 0] extremeColor();
        logic [COLOR_WIDTH - 1 : 0] color;
        for (int i = 0; i < CHANNEL_COUNT; i++)
        begin
            case ($urandom_range(2))
                0:       color[i * CHANNEL_WIDTH +: CHANNEL_WIDTH] = 8'h00;
                1:       color[i * CHANNEL_WIDTH +: CHANNEL_WIDTH] = 8'hff;
                default: color[i * CHANNEL_WIDTH +: CHANNEL_WIDTH] = 8'($urandom());
            endcase
        end
        return color;
    endfunction

    task automatic sendKnown(
        input string                      phase,
        input logic [MODE_WIDTH - 1 : 0]  mode,
        input logic [COLOR_WIDTH - 1 : 0] primary,
        input logic [COLOR_WIDTH - 1 : 0] texture,
        input logic [COLOR_WIDTH - 1 : 0] constColor,
        input logic [COLOR_WIDTH - 1 : 0] expected
    );
        @(posedge aclk);
        inValid <= 1'b1;
        combineMode <= mode;
        primaryColor <= primary;
        textureColor <= texture;
        constantColor <= constColor;
        expectedColors.push_back(expected);
        expectedTests.push_back({phase, " ", modeName(mode)});
    endtask

    task automatic sendFragment(
        input string                      phase,
        input logic [MODE_WIDTH - 1 : 0]  mode,
        input logic [COLOR_WIDTH - 1 : 0] primary,
        input logic [COLOR_WIDTH - 1 : 0] texture,
        input logic [COLOR_WIDTH - 1 : 0] constColor
    );
        sendKnown(phase, mode, primary, texture, constColor,
            modelColor(mode, primary, texture, constColor));
    endtask

    // Data still toggles so stale values cannot leak out
    task automatic driveIdle();
        @(posedge aclk);
        inValid <= 1'b0;
        combineMode <= MODE_WIDTH'($urandom_range(7));
        primaryColor <= $urandom();
        textureColor <= $urandom();
        constantColor <= $urandom();
    endtask

    task automatic runDirected();
        logic [COLOR_WIDTH - 1 : 0] texel;
        texel = 32'hff80_0100;
        sendKnown("directed", 3'd0, 32'h1122_3344, texel, 32'h5566_7788, texel);
        sendKnown("directed", 3'd5, 32'h1122_3344, texel, 32'h5566_7788, texel);
        sendKnown("directed", 3'd6, 32'hffff_ffff, texel, 32'h0000_0000, texel);
        sendKnown("directed", 3'd7, 32'h0000_0000, texel, 32'hffff_ffff, texel);
        sendKnown("directed", MODE_MODULATE, 32'hffff_ffff, 32'h12ab_00ff, '0, 32'h12ab_00ff);
        sendKnown("directed", MODE_MODULATE, 32'h0000_0000, 32'h12ab_00ff, '0, 32'h0000_0000);
        sendKnown("directed", MODE_ADD, 32'hc8c8_c8c8, 32'hc8c8_c8c8, '0, 32'hffff_ffff);
        sendKnown("directed", MODE_SUBTRACT, 32'hc8c8_c8c8, 32'h1000_0a05, '0, 32'h0000_0000);
        sendKnown("directed", MODE_SUBTRACT, 32'h0110_2020, 32'hff80_4020, '0, 32'hfe70_2000);
        sendKnown("directed", MODE_INTERPOLATE, 32'h0102_0304, 32'h5a3c_1e0f, 32'hffff_ffff,
            32'h5a3c_1e0f);
        sendKnown("directed", MODE_INTERPOLATE, 32'h0102_0304, 32'h5a3c_1e0f, 32'h0000_0000,
            32'h0102_0304);
        repeat (DIRECTED_CYCLES - 11) driveIdle();
    endtask

    // Outputs are stable at the falling edge
    always @(negedge aclk)
    begin
        if (!arstN && outValid !== 1'b0)
        begin
            $display("outValid is not low during reset at %0t", $time);
            unexpectedCount++;
        end
        else if (arstN && outValid === 1'b1)
        begin
            if (expectedColors.size() == 0)
            begin
                $display("outValid is high with no fragment outstanding at %0t", $time);
                unexpectedCount++;
            end
            else
            begin
                checkExpected = expectedColors.pop_front();
                checkTest = expectedTests.pop_front();
                checkedCount++;
                if (outColor !== checkExpected)
                begin
                    $display("FAILED %s: expected %08h, actual %08h",
                        checkTest, checkExpected, outColor);
                    mismatchCount++;
                end
            end
        end
    end

    initial
    begin
        #((TOTAL_CYCLES + RESET_CYCLES + 20) * CLOCK_PERIOD);
        $display("Timeout: the run did not finish in time, %0d fragments outstanding",
            expectedColors.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        aclk = 1'b0;
        arstN = 1'b0;
        inValid = 1'b0;
        combineMode = '0;
        primaryColor = '0;
        textureColor = '0;
        constantColor = '0;
        mismatchCount = 0;
        unexpectedCount = 0;
        missingCount = 0;
        checkedCount = 0;
        drainCycles = 0;
        void'($urandom(SEED));

        // Valid strobes in the first half of reset must not reach outValid
        @(posedge aclk);
        inValid <= 1'b1;
        repeat (RESET_CYCLES / 2 - 1) @(posedge aclk);
        inValid <= 1'b0;
        repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge aclk);
        arstN <= 1'b1;

        // Random traffic, valid about 75% of the cycles
        for (int n = 0; n < RANDOM_CYCLES; n++)
        begin
            if ($urandom_range(3) != 0)
                sendFragment("random", MODE_WIDTH'($urandom_range(7)),
                    $urandom(), $urandom(), $urandom());
            else
                driveIdle();
        end

        // Back to back burst with 0 and 255 channels
        for (int n = 0; n < EXTREME_CYCLES; n++)
        begin
            sendFragment("extreme", MODE_WIDTH'($urandom_range(7)),
                extremeColor(), extremeColor(), extremeColor());
        end

        runDirected();
        driveIdle();

        while (expectedColors.size() != 0 && drainCycles < DRAIN_LIMIT)
        begin
            @(posedge aclk);
            drainCycles++;
        end
        // A few more cycles to catch a stray outValid
        repeat (4) @(posedge aclk);

        missingCount = expectedColors.size();
        if (missingCount != 0)
            $display("%0d fragments never came out of the pipeline", missingCount);
        $display("Checked %0d fragments: %0d mismatches, %0d unexpected, %0d missing",
            checkedCount, mismatchCount, unexpectedCount, missingCount);
        if (mismatchCount + unexpectedCount + missingCount == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
combinerPkg.sv
mixerOperandIf.sv
combinerOperandSelect.sv
colorMixerSigned.sv
combinerOutputStage.sv
texEnvCombiner.sv
texEnvCombiner_sva.sv
tbTexEnvCombiner.sv

// File: Makefile
# Verilator build and run for the texture environment combiner

VERILATOR ?= verilator
TOP       ?= tbTexEnvCombiner
SIM_ARGS  ?=
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FILE_LIST := sources.f
SOURCES   := $(filter-out +%,$(shell cat $(FILE_LIST)))
HEADERS   := pixelUtil.svh
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
PASS_TEXT := *** TEST PASSED ***

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o V$(TOP) -f $(FILE_LIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
